//--- run.sh
#!/bin/sh
# Build and run the blimp testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module blimp_tb \
  -f src.f -o blimp_sim > build.log 2>&1 \
  && ./obj_dir/blimp_sim > sim.log 2>&1
grep -qx "Test passed" sim.log && echo "simulation passed" && exit 0 \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }

//--- src.f
verilog/blimp_pkg.sv
verilog/mem_port.sv
verilog/reg_file.sv
verilog/inst_decoder.sv
verilog/blimp_ctrl.sv
verilog/blimp_top.sv
tb/blimp_assertions.sv
tb/blimp_checker.sv
tb/blimp_tb.sv

//--- tb/blimp_assertions.sv
/*
 * Bound handshake and trace assertions for the blimp core
 * Four-phase rules on both memory ports, reset state and trace pulse width
 */
`timescale 1ns/1ps
`default_nettype none

module blimp_assertions (
  input wire logic                   clk,
  input wire logic                   rst,
  input wire logic                   imem_req,
  input wire logic                   imem_ack,
  input wire blimp_pkg::mem_req_t    imem_msg,
  input wire logic                   dmem_req,
  input wire logic                   dmem_ack,
  input wire blimp_pkg::mem_req_t    dmem_msg,
  input wire blimp_pkg::inst_trace_t trace
);
  import blimp_pkg::*;

  // Message held for the whole time req is high
  imem_msg_stable: assert property (@(posedge clk) disable iff (rst)
    (imem_req && $past(imem_req)) |-> $stable(imem_msg))
    else $error("imem message changed while req was high");

  dmem_msg_stable: assert property (@(posedge clk) disable iff (rst)
    (dmem_req && $past(dmem_req)) |-> $stable(dmem_msg))
    else $error("dmem message changed while req was high");

  // New req only after ack was seen low
  imem_req_after_release: assert property (@(posedge clk) disable iff (rst)
    $rose(imem_req) |-> !$past(imem_ack))
    else $error("imem req rose while ack was high");

  dmem_req_after_release: assert property (@(posedge clk) disable iff (rst)
    $rose(dmem_req) |-> !$past(dmem_ack))
    else $error("dmem req rose while ack was high");

  // Quiet first cycle out of reset
  quiet_after_reset: assert property (@(posedge clk)
    $fell(rst) |-> (!imem_req && !dmem_req && !trace.val))
    else $error("req or trace valid high right after reset");

  // One retirement per pulse
  trace_single_cycle: assert property (@(posedge clk) disable iff (rst)
    trace.val |=> !trace.val)
    else $error("trace valid held for two cycles");

endmodule

bind blimp_top blimp_assertions u_assertions (
  .clk      (clk),
  .rst      (rst),
  .imem_req (imem_req),
  .imem_ack (imem_ack),
  .imem_msg (imem_msg),
  .dmem_req (dmem_req),
  .dmem_ack (dmem_ack),
  .dmem_msg (dmem_msg),
  .trace    (trace)
);

`default_nettype wire

//--- tb/blimp_checker.sv
/*
 * Instruction-set model for the blimp core
 * Steps once per trace record and compares pc, waddr, wdata and wen
 */
`timescale 1ns/1ps
`default_nettype none

module blimp_checker #(
  parameter int num_insts = 200
) (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire blimp_pkg::inst_trace_t trace,
  output int                          errors,
  output logic                        finished
);
  import blimp_pkg::*;

  word_t regs [32];
  word_t mem [64];
  addr_t pc;

  // Last program slot holds the self-loop
  localparam addr_t end_pc = reset_pc + (num_insts - 1) * 4;

  task automatic compare(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("mismatch %s: expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  always @(posedge clk) begin
    word_t   inst;
    word_t   imm_i;
    word_t   imm_j;
    word_t   res;
    word_t   addr;
    addr_t   npc;
    logic    wr;
    logic    exp_wen;
    string   name;
    int      slot;
    if (rst) begin
      pc       = reset_pc;
      finished = 1'b0;
      errors   = 0;
      for (int i = 0; i < 32; i++) regs[i] = '0;
      for (int i = 0; i < 64; i++) mem[i] = blimp_tb.init_data[i];
    end else if (trace.val && !finished) begin
      slot = int'((pc - reset_pc) >> 2);
      inst = (slot >= 0 && slot < num_insts) ? blimp_tb.prog[slot] : '0;
      imm_i = {{20{inst[31]}}, inst[31:20]};
      imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      npc  = pc + 4;
      res  = '0;
      wr   = 1'b1;
      name = "illegal";
      case (inst[6:0])
        opc_op_imm: begin
          name = "addi";
          res  = regs[inst[19:15]] + imm_i;
        end
        opc_op: begin
          name = inst[25] ? "mul" : "add";
          res  = inst[25] ? regs[inst[19:15]] * regs[inst[24:20]]
                          : regs[inst[19:15]] + regs[inst[24:20]];
        end
        opc_load: begin
          name = "lw";
          addr = regs[inst[19:15]] + imm_i;
          res  = mem[addr[7:2]];
        end
        opc_store: begin
          name = "sw";
          wr   = 1'b0;
          addr = regs[inst[19:15]] + {{20{inst[31]}}, inst[31:25], inst[11:7]};
          mem[addr[7:2]] = regs[inst[24:20]];
        end
        opc_jal: begin
          name = "jal";
          res  = pc + 4;
          npc  = pc + imm_j;
        end
        opc_jalr: begin
          name = "jalr";
          res  = pc + 4;
          npc  = (regs[inst[19:15]] + imm_i) & ~32'd1;
        end
        default: wr = 1'b0;
      endcase
      exp_wen = wr && (inst[11:7] != 5'd0);
      compare({name, " pc"}, pc, trace.pc);
      compare({name, " wen"}, {31'd0, exp_wen}, {31'd0, trace.wen});
      // Destination fields only carry meaning when a register is written
      if (exp_wen) begin
        compare({name, " waddr"}, {27'd0, inst[11:7]}, {27'd0, trace.waddr});
        compare({name, " wdata"}, res, trace.wdata);
        regs[inst[11:7]] = res;
      end
      if (pc == end_pc) finished = 1'b1;
      pc = npc;
    end
  end

endmodule

`default_nettype wire

//--- tb/blimp_tb.sv
/*
 * Blimp core testbench
 * Random program, four-phase memory responders, timeout and final report
 */
`timescale 1ns/1ps
`default_nettype none

module blimp_tb;
  import blimp_pkg::*;

  localparam int num_insts  = 200;
  // About 20 worst-case cycles per instruction plus margin
  localparam int max_cycles = num_insts * 20 + 2000;
  localparam word_t filler  = {12'h7ff, 5'd0, 3'b000, 5'd1, opc_op_imm};

  logic        clk;
  logic        rst;
  logic        imem_req;
  logic        imem_ack;
  mem_req_t    imem_msg;
  mem_resp_t   imem_resp;
  logic        dmem_req;
  logic        dmem_ack;
  mem_req_t    dmem_msg;
  mem_resp_t   dmem_resp;
  inst_trace_t trace;

  word_t prog [num_insts];
  word_t init_data [64];
  word_t data_mem [64];
  logic [31:0] gen_rng;
  logic [31:0] imem_rng;
  logic [31:0] dmem_rng;
  int          cycles;
  int          errors;
  int          timeouts;
  logic        finished;

  blimp_top u_blimp_top (
    .clk       (clk),
    .rst       (rst),
    .imem_req  (imem_req),
    .imem_ack  (imem_ack),
    .imem_msg  (imem_msg),
    .imem_resp (imem_resp),
    .dmem_req  (dmem_req),
    .dmem_ack  (dmem_ack),
    .dmem_msg  (dmem_msg),
    .dmem_resp (dmem_resp),
    .trace     (trace)
  );

  blimp_checker #(
    .num_insts (num_insts)
  ) u_checker (
    .clk      (clk),
    .rst      (rst),
    .trace    (trace),
    .errors   (errors),
    .finished (finished)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // ------------------------------------------------------------------------
  // Instruction encoders
  // ------------------------------------------------------------------------
  function automatic word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                  input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, 3'b000, rd, opc};
  endfunction

  function automatic word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                  input logic [4:0] rs1, input logic [4:0] rd);
    return {f7, rs2, rs1, 3'b000, rd, opc_op};
  endfunction

  // Word load off x0
  function automatic word_t enc_lw(input logic [11:0] imm, input logic [4:0] rd);
    return {imm, 5'd0, 3'b010, rd, opc_load};
  endfunction

  function automatic word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2);
    return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], opc_store};
  endfunction

  function automatic word_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
  endfunction

  task automatic gen_program();
    int          idx;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] off;
    logic [31:0] target;
    gen_rng = 32'h013aa94e;
    for (int i = 0; i < 64; i++) begin
      gen_rng      = xorshift(gen_rng);
      init_data[i] = gen_rng;
      data_mem[i]  = gen_rng;
    end
    idx = 0;
    // Seed x1 to x7
    for (int r = 1; r <= 7; r++) begin
      gen_rng   = xorshift(gen_rng);
      prog[idx] = enc_i(gen_rng[11:0], 5'd0, 5'(r), opc_op_imm);
      idx++;
    end
    while (idx < num_insts - 1) begin
      gen_rng = xorshift(gen_rng);
      rd  = 5'(1 + gen_rng[11:8] % 15);
      rs1 = 5'(1 + gen_rng[15:12] % 15);
      rs2 = 5'(1 + gen_rng[19:16] % 15);
      off = {4'd0, gen_rng[25:20], 2'b00};
      if (gen_rng[3:0] == 4'd0 && idx + 2 <= num_insts - 1) begin
        prog[idx]     = enc_j(21'd8, rd);
        prog[idx + 1] = filler;
        idx += 2;
      end else if (gen_rng[3:0] == 4'd1 && idx + 3 <= num_insts - 1) begin
        // Odd offset checks that bit 0 of the target is cleared
        target        = reset_pc + (idx + 3) * 4;
        prog[idx]     = enc_i(target[11:0], 5'd0, 5'd16, opc_op_imm);
        prog[idx + 1] = enc_i(12'd1, 5'd16, rd, opc_jalr);
        prog[idx + 2] = filler;
        idx += 3;
      end else begin
        case (gen_rng[3:0])
          4'd2, 4'd3, 4'd4: prog[idx] = enc_lw(off, rd);
          4'd5, 4'd6, 4'd7: prog[idx] = enc_s(off, rs2);
          4'd8, 4'd9:       prog[idx] = enc_r(7'b0000001, rs2, rs1, rd);
          4'd10, 4'd11:     prog[idx] = enc_r(7'b0000000, rs2, rs1, rd);
          // Occasional x0 destination
          4'd12:            prog[idx] = enc_i(gen_rng[31:20], rs1, 5'd0, opc_op_imm);
          default:          prog[idx] = enc_i(gen_rng[31:20], rs1, rd, opc_op_imm);
        endcase
        idx++;
      end
    end
    prog[num_insts - 1] = enc_j(21'd0, 5'd0);
    imem_rng = gen_rng ^ 32'h5a5a_1234;
    dmem_rng = xorshift(gen_rng);
  endtask

  function automatic word_t fetch_word(input addr_t addr);
    int slot;
    slot = int'((addr - reset_pc) >> 2);
    return (slot >= 0 && slot < num_insts) ? prog[slot] : '0;
  endfunction

  // ------------------------------------------------------------------------
  // Clock, reset and run control
  // ------------------------------------------------------------------------
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cycles <= cycles + 1;

  initial begin
    rst       = 1'b1;
    imem_ack  = 1'b0;
    imem_resp = '0;
    dmem_ack  = 1'b0;
    dmem_resp = '0;
    cycles    = 0;
    timeouts  = 0;
    gen_program();
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;
    while (!finished && cycles < max_cycles) @(posedge clk);
    if (!finished) begin
      $display("hang: the program did not reach its self-loop within %0d cycles", max_cycles);
      timeouts++;
    end
    $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // ------------------------------------------------------------------------
  // Instruction memory responder
  // ------------------------------------------------------------------------
  initial begin
    forever begin
      @(posedge clk);
      #1;
      if (!rst && imem_req) begin
        imem_rng = xorshift(imem_rng);
        repeat (imem_rng[1:0]) begin
          @(posedge clk);
          #1;
        end
        imem_resp.rdata = fetch_word(imem_msg.addr);
        imem_ack        = 1'b1;
        while (imem_req) begin
          @(posedge clk);
          #1;
        end
        imem_rng = xorshift(imem_rng);
        repeat (imem_rng[1:0]) begin
          @(posedge clk);
          #1;
        end
        imem_ack = 1'b0;
      end
    end
  end

  // Data memory responder that applies writes to data_mem
  initial begin
    forever begin
      @(posedge clk);
      #1;
      if (!rst && dmem_req) begin
        dmem_rng = xorshift(dmem_rng);
        repeat (dmem_rng[1:0]) begin
          @(posedge clk);
          #1;
        end
        if (dmem_msg.write) data_mem[dmem_msg.addr[7:2]] = dmem_msg.wdata;
        dmem_resp.rdata = data_mem[dmem_msg.addr[7:2]];
        dmem_ack        = 1'b1;
        while (dmem_req) begin
          @(posedge clk);
          #1;
        end
        dmem_rng = xorshift(dmem_rng);
        repeat (dmem_rng[1:0]) begin
          @(posedge clk);
          #1;
        end
        dmem_ack = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/blimp_ctrl.sv
/*
 * Blimp controller
 * Multi-cycle sequencing, pc, ALU with multiply, data address and trace output
 */
`timescale 1ns/1ps
`default_nettype none

module blimp_ctrl (
  input  wire logic                 clk,
  input  wire logic                 rst,
  output logic                      imem_start,
  output blimp_pkg::mem_req_t       imem_req,
  input  wire logic                 imem_done,
  input  wire blimp_pkg::mem_resp_t imem_resp,
  output logic                      dmem_start,
  output blimp_pkg::mem_req_t       dmem_req,
  input  wire logic                 dmem_done,
  input  wire blimp_pkg::mem_resp_t dmem_resp,
  output blimp_pkg::word_t          inst,
  input  wire blimp_pkg::decoded_t  dec,
  input  wire blimp_pkg::word_t     rf_rdata0,
  input  wire blimp_pkg::word_t     rf_rdata1,
  output logic                      rf_wen,
  output blimp_pkg::reg_idx_t       rf_waddr,
  output blimp_pkg::word_t          rf_wdata,
  output blimp_pkg::inst_trace_t    trace
);
  import blimp_pkg::*;

  ctrl_state_t state;
  addr_t       pc;
  // Set once the current access has been launched
  logic        issued;

  // Latched instruction and operands
  word_t       ir;
  alu_op_t     op_r;
  reg_idx_t    rd_r;
  word_t       imm_r;
  word_t       opa;
  word_t       opb;
  word_t       result;
  addr_t       npc;

  // ALU signals
  word_t       alu_b;
  word_t       sum;
  word_t       prod;
  word_t       link;
  word_t       alu_out;
  addr_t       next_pc;
  logic        writes_rd;

  assign inst = ir;

  // ------------------------------------------------------------------------
  // ALU and next pc
  // ------------------------------------------------------------------------
  assign alu_b = (op_r == op_add) ? opb : imm_r;
  assign sum   = opa + alu_b;
  assign prod  = opa * opb;
  assign link  = pc + 32'd4;

  always_comb begin
    case (op_r)
      op_mul:  alu_out = prod;
      op_jal,
      op_jalr: alu_out = link;
      default: alu_out = sum;
    endcase
    case (op_r)
      op_jal:  next_pc = pc + imm_r;
      // Target bit 0 dropped
      op_jalr: next_pc = sum & ~32'd1;
      default: next_pc = link;
    endcase
  end

  // sw and illegal leave the register file alone
  assign writes_rd = (op_r != op_sw) && (op_r != op_illegal);

  // ------------------------------------------------------------------------
  // Memory requests
  // ------------------------------------------------------------------------
  assign imem_start = (state == st_fetch) && !issued;
  assign dmem_start = (state == st_mem_access) && !issued;

  always_comb begin
    imem_req.write = 1'b0;
    imem_req.addr  = pc;
    imem_req.wdata = '0;
    dmem_req.write = (op_r == op_sw);
    dmem_req.addr  = result;
    dmem_req.wdata = opb;
  end

  // ------------------------------------------------------------------------
  // Sequencing
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= st_fetch;
      pc     <= reset_pc;
      issued <= 1'b0;
    end else begin
      if (imem_start || dmem_start) issued <= 1'b1;
      else if (imem_done || dmem_done) issued <= 1'b0;
      case (state)
        st_fetch:      if (imem_done) state <= st_decode;
        st_decode:     state <= st_execute;
        st_execute:
          state <= (op_r == op_lw || op_r == op_sw) ? st_mem_access : st_writeback;
        st_mem_access: if (dmem_done) state <= st_writeback;
        st_writeback: begin
          pc    <= npc;
          state <= st_fetch;
        end
        default:       state <= st_fetch;
      endcase
    end
  end

  // Datapath registers
  always_ff @(posedge clk) begin
    if (state == st_fetch && imem_done) ir <= imem_resp.rdata;
    if (state == st_decode) begin
      op_r  <= dec.op;
      rd_r  <= dec.rd;
      imm_r <= dec.imm;
      opa   <= rf_rdata0;
      opb   <= rf_rdata1;
    end
    if (state == st_execute) begin
      result <= alu_out;
      npc    <= next_pc;
    end
    // Load data replaces the address
    if (state == st_mem_access && dmem_done && op_r == op_lw) result <= dmem_resp.rdata;
  end

  // ------------------------------------------------------------------------
  // Writeback and trace
  // ------------------------------------------------------------------------
  assign rf_wen   = (state == st_writeback) && writes_rd && (rd_r != '0);
  assign rf_waddr = rd_r;
  assign rf_wdata = result;

  always_comb begin
    trace.val   = (state == st_writeback);
    trace.pc    = pc;
    trace.waddr = rd_r;
    trace.wdata = result;
    trace.wen   = rf_wen;
  end

endmodule

`default_nettype wire

//--- verilog/blimp_pkg.sv
/*
 * Blimp shared definitions
 * Widths, opcodes, memory messages, decoded fields and the trace record
 */
`default_nettype none

package blimp_pkg;

  // Meaningful widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  // First pc after reset
  localparam addr_t reset_pc = 32'h0000_0200;

  // RV32 major opcodes that the core understands
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;

  // Decoded operation
  typedef enum logic [2:0] {
    op_addi,
    op_add,
    op_mul,
    op_lw,
    op_sw,
    op_jal,
    op_jalr,
    op_illegal
  } alu_op_t;

  // Controller sequencing
  typedef enum logic [2:0] {
    st_fetch,
    st_decode,
    st_execute,
    st_mem_access,
    st_writeback
  } ctrl_state_t;

  // Memory request, 65 bits
  typedef struct packed {
    logic  write;
    addr_t addr;
    word_t wdata;
  } mem_req_t;

  // Memory response, read data only
  typedef struct packed {
    word_t rdata;
  } mem_resp_t;

  // One record per retired instruction, 71 bits
  typedef struct packed {
    logic     val;
    addr_t    pc;
    reg_idx_t waddr;
    word_t    wdata;
    logic     wen;
  } inst_trace_t;

  // Decoder output
  typedef struct packed {
    alu_op_t  op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    imm;
  } decoded_t;

endpackage

`default_nettype wire

//--- verilog/blimp_top.sv
/*
 * Blimp core top level
 * Controller, decoder, register file and the two four-phase memory ports
 */
`timescale 1ns/1ps
`default_nettype none

module blimp_top (
  input  wire logic                 clk,
  input  wire logic                 rst,
  output logic                      imem_req,
  input  wire logic                 imem_ack,
  output blimp_pkg::mem_req_t       imem_msg,
  input  wire blimp_pkg::mem_resp_t imem_resp,
  output logic                      dmem_req,
  input  wire logic                 dmem_ack,
  output blimp_pkg::mem_req_t       dmem_msg,
  input  wire blimp_pkg::mem_resp_t dmem_resp,
  output blimp_pkg::inst_trace_t    trace
);
  import blimp_pkg::*;

  // Controller to port
  logic      imem_start;
  logic      imem_done;
  mem_req_t  imem_creq;
  mem_resp_t imem_cresp;
  logic      dmem_start;
  logic      dmem_done;
  mem_req_t  dmem_creq;
  mem_resp_t dmem_cresp;

  // Decode and register file
  word_t     inst;
  decoded_t  dec;
  word_t     rf_rdata0;
  word_t     rf_rdata1;
  logic      rf_wen;
  reg_idx_t  rf_waddr;
  word_t     rf_wdata;

  blimp_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .imem_start (imem_start),
    .imem_req   (imem_creq),
    .imem_done  (imem_done),
    .imem_resp  (imem_cresp),
    .dmem_start (dmem_start),
    .dmem_req   (dmem_creq),
    .dmem_done  (dmem_done),
    .dmem_resp  (dmem_cresp),
    .inst       (inst),
    .dec        (dec),
    .rf_rdata0  (rf_rdata0),
    .rf_rdata1  (rf_rdata1),
    .rf_wen     (rf_wen),
    .rf_waddr   (rf_waddr),
    .rf_wdata   (rf_wdata),
    .trace      (trace)
  );

  inst_decoder u_decoder (
    .inst (inst),
    .dec  (dec)
  );

  // Read ports addressed straight from the decoder
  reg_file u_reg_file (
    .clk    (clk),
    .rst    (rst),
    .raddr0 (dec.rs1),
    .raddr1 (dec.rs2),
    .rdata0 (rf_rdata0),
    .rdata1 (rf_rdata1),
    .wen    (rf_wen),
    .waddr  (rf_waddr),
    .wdata  (rf_wdata)
  );

  mem_port u_imem_port (
    .clk      (clk),
    .rst      (rst),
    .start    (imem_start),
    .req_msg  (imem_creq),
    .done     (imem_done),
    .resp_msg (imem_cresp),
    .busy     (),
    .req      (imem_req),
    .ack      (imem_ack),
    .msg      (imem_msg),
    .resp     (imem_resp)
  );

  mem_port u_dmem_port (
    .clk      (clk),
    .rst      (rst),
    .start    (dmem_start),
    .req_msg  (dmem_creq),
    .done     (dmem_done),
    .resp_msg (dmem_cresp),
    .busy     (),
    .req      (dmem_req),
    .ack      (dmem_ack),
    .msg      (dmem_msg),
    .resp     (dmem_resp)
  );

endmodule

`default_nettype wire

//--- verilog/inst_decoder.sv
/*
 * Instruction decoder
 * Register indices, selected immediate and operation for the RV32 subset
 */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
  input  wire blimp_pkg::word_t inst,
  output blimp_pkg::decoded_t   dec
);
  import blimp_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_j;
  alu_op_t    op;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // ------------------------------------------------------------------------
  // Immediates, all sign extended from bit 31
  // ------------------------------------------------------------------------
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  // J-type is scrambled, low bit always zero
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // ------------------------------------------------------------------------
  // Operation match
  // ------------------------------------------------------------------------
  always_comb begin
    op = op_illegal;
    case (opcode)
      opc_op_imm: if (funct3 == 3'b000) op = op_addi;
      opc_op: begin
        if (funct3 == 3'b000 && funct7 == 7'b0000000) op = op_add;
        // M extension, low half of the product only
        if (funct3 == 3'b000 && funct7 == 7'b0000001) op = op_mul;
      end
      opc_load:   if (funct3 == 3'b010) op = op_lw;
      opc_store:  if (funct3 == 3'b010) op = op_sw;
      opc_jal:    op = op_jal;
      opc_jalr:   if (funct3 == 3'b000) op = op_jalr;
      default:    op = op_illegal;
    endcase
  end

  // Field extraction
  always_comb begin
    dec.op  = op;
    dec.rd  = inst[11:7];
    dec.rs1 = inst[19:15];
    dec.rs2 = inst[24:20];
    case (op)
      op_sw:   dec.imm = imm_s;
      op_jal:  dec.imm = imm_j;
      op_add,
      op_mul:  dec.imm = '0;
      default: dec.imm = imm_i;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/mem_port.sv
/*
 * Four-phase memory requester
 * Turns a one-cycle start into one req/ack handshake and returns the response
 */
`timescale 1ns/1ps
`default_nettype none

module mem_port (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 start,
  input  wire blimp_pkg::mem_req_t  req_msg,
  output logic                      done,
  output blimp_pkg::mem_resp_t      resp_msg,
  output logic                      busy,
  output logic                      req,
  input  wire logic                 ack,
  output blimp_pkg::mem_req_t       msg,
  input  wire blimp_pkg::mem_resp_t resp
);
  import blimp_pkg::*;

  typedef enum logic [1:0] {
    idle,
    wait_ack,
    wait_release
  } port_state_t;

  port_state_t state;
  // Start seen while the previous ack was still high
  logic        pending;

  assign busy = (state != idle);

  // ------------------------------------------------------------------------
  // Handshake sequencing
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= idle;
      req     <= 1'b0;
      done    <= 1'b0;
      pending <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        idle: begin
          if (start) begin
            req   <= 1'b1;
            state <= wait_ack;
          end
        end
        wait_ack: begin
          // Stable response releases req and reports
          if (ack) begin
            req   <= 1'b0;
            done  <= 1'b1;
            state <= wait_release;
          end
        end
        wait_release: begin
          if (start) pending <= 1'b1;
          // Next req only once ack is seen low
          if (!ack) begin
            if (pending || start) begin
              req     <= 1'b1;
              pending <= 1'b0;
              state   <= wait_ack;
            end else begin
              state <= idle;
            end
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // Message held from start until the handshake ends
  always_ff @(posedge clk) begin
    if (start && state != wait_ack) msg <= req_msg;
    if (state == wait_ack && ack) resp_msg <= resp;
  end

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
/*
 * Architectural register file
 * 32 words, two combinational reads, one write per edge, x0 fixed at zero
 */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire blimp_pkg::reg_idx_t raddr0,
  input  wire blimp_pkg::reg_idx_t raddr1,
  output blimp_pkg::word_t         rdata0,
  output blimp_pkg::word_t         rdata1,
  input  wire logic                wen,
  input  wire blimp_pkg::reg_idx_t waddr,
  input  wire blimp_pkg::word_t    wdata
);
  import blimp_pkg::*;

  word_t regs [32];

  // Reset clears every register
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 always reads zero
  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

`default_nettype wire
